// File: rtl/convPkg.sv
// shared pixel constants, pixel type and default sizes of the convolution engine
`default_nettype none

package convPkg;

    //////////////////////////////////////////////////////////////////////
    // default engine sizes
    //////////////////////////////////////////////////////////////////////

    // number of taps, a power of two and at least 2
    localparam int DefaultNumTaps = 8;

    // signed samples and weights share this width
    localparam int DefaultDataWidth = 16;

    //////////////////////////////////////////////////////////////////////
    // pixel output
    //////////////////////////////////////////////////////////////////////

    localparam int PixelWidth = 8;

    // magnitude of the sum saturates here
    localparam int PixelMax = 255;

    typedef logic [PixelWidth-1:0] pixelT;

endpackage

`default_nettype wire

// File: rtl/tapCell.sv
// one processing element of the convolution chain: weight, sample and product registers
`timescale 1ns/1ns
`default_nettype none

module tapCell #(
    parameter int DataWidth = convPkg::DefaultDataWidth
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          weightLoad,
    input  logic signed [DataWidth-1:0]   weightValue,
    input  logic signed [DataWidth-1:0]   sampleIn,
    input  logic                          shift,
    output logic signed [DataWidth-1:0]   sampleOut,
    output logic signed [2*DataWidth-1:0] product
);

    logic signed [DataWidth-1:0] weight;

    // weight stays put until the host rewrites this tap
    always_ff @(posedge clk) begin
        if (rst) begin
            weight <= '0;
        end else if (weightLoad) begin
            weight <= weightValue;
        end
    end

    // the product uses the weight held before this edge,
    // so a weight written together with a sample applies to later samples only
    always_ff @(posedge clk) begin
        if (rst) begin
            sampleOut <= '0;
            product   <= '0;
        end else if (shift) begin
            sampleOut <= sampleIn;
            product   <= weight * sampleIn;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tapChain.sv
// weight-stationary chain of taps with weight index decode and sample pass-through
`timescale 1ns/1ns
`default_nettype none

module tapChain #(
    parameter int NumTaps   = convPkg::DefaultNumTaps,
    parameter int DataWidth = convPkg::DefaultDataWidth
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          loadWeight,
    input  logic [$clog2(NumTaps)-1:0]    weightIndex,
    input  logic signed [DataWidth-1:0]   weightValue,
    input  logic                          sampleValid,
    input  logic signed [DataWidth-1:0]   sample,
    output logic signed [2*DataWidth-1:0] products [NumTaps]
);

    localparam int IndexWidth = $clog2(NumTaps);

    logic [NumTaps-1:0]          weightLoad;
    logic signed [DataWidth-1:0] taps [NumTaps];

    //////////////////////////////////////////////////////////////////////
    // weight write decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < NumTaps; k++) begin
            weightLoad[k] = loadWeight && (weightIndex == IndexWidth'(k));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tap cells
    //////////////////////////////////////////////////////////////////////

    // tap k holds x[n-k] once sample x[n] has been accepted
    for (genvar k = 0; k < NumTaps; k++) begin : gTap
        logic signed [DataWidth-1:0] sampleIn;

        if (k == 0) begin : gHead
            assign sampleIn = sample;
        end else begin : gLink
            assign sampleIn = taps[k-1];
        end

        tapCell #(
            .DataWidth(DataWidth)
        ) i_tapCell (
            .clk        (clk),
            .rst        (rst),
            .weightLoad (weightLoad[k]),
            .weightValue(weightValue),
            .sampleIn   (sampleIn),
            .shift      (sampleValid),
            .sampleOut  (taps[k]),
            .product    (products[k])
        );
    end

endmodule

`default_nettype wire

// File: rtl/adderTree.sv
// pipelined binary reduction of the tap products into a single sum
`timescale 1ns/1ns
`default_nettype none

module adderTree #(
    parameter int NumTaps   = convPkg::DefaultNumTaps,
    parameter int DataWidth = convPkg::DefaultDataWidth,
    parameter int AccWidth  = 2 * DataWidth + $clog2(NumTaps)
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic signed [2*DataWidth-1:0] products [NumTaps],
    output logic signed [AccWidth-1:0]    sum
);

    // the tree is kept as a heap: node 0 is the root, children of node i
    // sit at 2i+1 and 2i+2, and the last NumTaps entries are the leaves
    localparam int NumNodes = NumTaps - 1;
    localparam int NumEntries = 2 * NumTaps - 1;

    // registered adders, one per internal node
    logic signed [AccWidth-1:0] node [NumNodes];

    // every heap entry: internal nodes followed by sign-extended products
    logic signed [AccWidth-1:0] entry [NumEntries];

    //////////////////////////////////////////////////////////////////////
    // heap view of the tree
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NumNodes; i++) begin
            entry[i] = node[i];
        end
        for (int k = 0; k < NumTaps; k++) begin
            entry[NumNodes + k] = AccWidth'(products[k]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // adder levels
    //////////////////////////////////////////////////////////////////////

    // all leaves sit at the same depth, so each level is one register stage
    // and the tree takes log2(NumTaps) cycles; no enable, a new set of
    // products may enter on every edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumNodes; i++) begin
                node[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumNodes; i++) begin
                node[i] <= entry[2*i + 1] + entry[2*i + 2];
            end
        end
    end

    assign sum = entry[0];

endmodule

`default_nettype wire

// File: rtl/convControl.sv
// fill counter and valid delay line marking which sums are real results
`timescale 1ns/1ns
`default_nettype none

module convControl #(
    parameter int NumTaps = convPkg::DefaultNumTaps
) (
    input  logic clk,
    input  logic rst,
    input  logic sampleValid,
    output logic sumValid
);

    localparam int FillWidth = $clog2(NumTaps + 1);

    // one stage for the tap products, then one per adder level
    localparam int Delay = 1 + $clog2(NumTaps);

    logic [FillWidth-1:0] fillCount;
    logic                 chainFull;
    logic [Delay-1:0]     validPipe;

    //////////////////////////////////////////////////////////////////////
    // fill counter
    //////////////////////////////////////////////////////////////////////

    // accepted samples since reset, saturating at NumTaps
    always_ff @(posedge clk) begin
        if (rst) begin
            fillCount <= '0;
        end else if (sampleValid && (fillCount != FillWidth'(NumTaps))) begin
            fillCount <= fillCount + 1'b1;
        end
    end

    // the sample being accepted now is at least the NumTaps-th one
    assign chainFull = fillCount >= FillWidth'(NumTaps - 1);

    //////////////////////////////////////////////////////////////////////
    // valid delay line
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[Delay-2:0], sampleValid && chainFull};
        end
    end

    // lines up with the root of the adder tree
    assign sumValid = validPipe[Delay-1];

endmodule

`default_nettype wire

// File: rtl/resultStage.sv
// output register for the signed sum, the saturated pixel and the valid flag
`timescale 1ns/1ns
`default_nettype none

module resultStage #(
    parameter int AccWidth = 2 * convPkg::DefaultDataWidth + $clog2(convPkg::DefaultNumTaps)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic signed [AccWidth-1:0] sum,
    input  logic                       sumValid,
    output logic signed [AccWidth-1:0] result,
    output convPkg::pixelT             pixel,
    output logic                       resultValid
);

    import convPkg::*;

    // unsigned, so the most negative sum still gives the right magnitude
    logic [AccWidth-1:0] magnitude;
    pixelT               pixelNext;

    assign magnitude = sum[AccWidth-1] ? -sum : sum;

    // clamp the magnitude to the pixel range
    assign pixelNext = (magnitude > AccWidth'(PixelMax)) ? pixelT'(PixelMax)
                                                         : magnitude[PixelWidth-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            result      <= '0;
            pixel       <= '0;
            resultValid <= 1'b0;
        end else begin
            result      <= sum;
            pixel       <= pixelNext;
            resultValid <= sumValid;
        end
    end

endmodule

`default_nettype wire

// File: rtl/convEngine.sv
// streaming 1-D convolution engine: tap chain, adder tree, fill control and output stage
`timescale 1ns/1ns
`default_nettype none

module convEngine #(
    parameter int NumTaps   = convPkg::DefaultNumTaps,
    parameter int DataWidth = convPkg::DefaultDataWidth,
    // room for the products plus one carry bit per adder level
    localparam int AccWidth = 2 * DataWidth + $clog2(NumTaps)
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        loadWeight,
    input  logic [$clog2(NumTaps)-1:0]  weightIndex,
    input  logic signed [DataWidth-1:0] weightValue,
    input  logic                        sampleValid,
    input  logic signed [DataWidth-1:0] sample,
    output logic                        resultValid,
    output logic signed [AccWidth-1:0]  result,
    output convPkg::pixelT              pixel
);

    logic signed [2*DataWidth-1:0] products [NumTaps];
    logic signed [AccWidth-1:0]    sum;
    logic                          sumValid;

    // the heap-shaped adder tree needs a full binary tree
    if ((NumTaps < 2) || ((NumTaps & (NumTaps - 1)) != 0)) begin : gSizeCheck
        $error("NumTaps must be a power of two and at least 2");
    end

    //////////////////////////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////////////////////////

    tapChain #(
        .NumTaps  (NumTaps),
        .DataWidth(DataWidth)
    ) i_tapChain (
        .clk        (clk),
        .rst        (rst),
        .loadWeight (loadWeight),
        .weightIndex(weightIndex),
        .weightValue(weightValue),
        .sampleValid(sampleValid),
        .sample     (sample),
        .products   (products)
    );

    adderTree #(
        .NumTaps  (NumTaps),
        .DataWidth(DataWidth),
        .AccWidth (AccWidth)
    ) i_adderTree (
        .clk     (clk),
        .rst     (rst),
        .products(products),
        .sum     (sum)
    );

    //////////////////////////////////////////////////////////////////////
    // control and output
    //////////////////////////////////////////////////////////////////////

    convControl #(
        .NumTaps(NumTaps)
    ) i_convControl (
        .clk        (clk),
        .rst        (rst),
        .sampleValid(sampleValid),
        .sumValid   (sumValid)
    );

    resultStage #(
        .AccWidth(AccWidth)
    ) i_resultStage (
        .clk        (clk),
        .rst        (rst),
        .sum        (sum),
        .sumValid   (sumValid),
        .result     (result),
        .pixel      (pixel),
        .resultValid(resultValid)
    );

endmodule

`default_nettype wire

// File: sim/convEngine_chk.sv
// checker bound to the convolution engine for reset, latency, pixel range and known result
`timescale 1ns/1ns
`default_nettype none

module convEngineChk #(
    parameter int NumTaps  = convPkg::DefaultNumTaps,
    parameter int AccWidth = 2 * convPkg::DefaultDataWidth + $clog2(convPkg::DefaultNumTaps)
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       sampleValid,
    input logic                       resultValid,
    input logic signed [AccWidth-1:0] result,
    input convPkg::pixelT             pixel
);

    import convPkg::*;

    // sample edge to the edge that first sees resultValid high
    localparam int Lag = 2 + $clog2(NumTaps);

    // magnitude of the result as a wide signed value
    longint resultMag;

    assign resultMag = (result < 0) ? -longint'(result) : longint'(result);

    assert property (@(posedge clk) (rst && $past(rst)) |-> !resultValid)
        else $error("resultValid high during reset");

    assert property (@(posedge clk) disable iff (rst) resultValid |-> $past(sampleValid, Lag))
        else $error("resultValid without an accepted sample at the pipeline latency");

    assert property (@(posedge clk) disable iff (rst)
        resultValid |-> longint'(pixel) == ((resultMag > PixelMax) ? PixelMax : resultMag))
        else $error("pixel is not the magnitude of result clamped to the saturation value");

    assert property (@(posedge clk) disable iff (rst) resultValid |-> !$isunknown(result))
        else $error("result has unknown bits while valid");

endmodule

bind convEngine convEngineChk #(
    .NumTaps (NumTaps),
    .AccWidth(AccWidth)
) i_convEngineChk (
    .clk        (clk),
    .rst        (rst),
    .sampleValid(sampleValid),
    .resultValid(resultValid),
    .result     (result),
    .pixel      (pixel)
);

`default_nettype wire

// File: sim/convEngineTb.sv
// convolution engine testbench with clock, reset, random stimulus, model, checks and summary
`timescale 1ns/1ns
`default_nettype none

module convEngineTb;

    import convPkg::*;

    localparam int NumTaps    = DefaultNumTaps;
    localparam int DataWidth  = DefaultDataWidth;
    localparam int AccWidth   = 2 * DataWidth + $clog2(NumTaps);
    localparam int IndexWidth = $clog2(NumTaps);
    localparam int Latency    = 1 + $clog2(NumTaps);
    localparam int DrainLimit = 50;
    localparam int WatchdogNs = 200000;

    logic                        clk;
    logic                        rst;
    logic                        loadWeight;
    logic [IndexWidth-1:0]       weightIndex;
    logic signed [DataWidth-1:0] weightValue;
    logic                        sampleValid;
    logic signed [DataWidth-1:0] sample;
    logic                        resultValid;
    logic signed [AccWidth-1:0]  result;
    pixelT                       pixel;

    // reference model state
    longint weights [NumTaps];
    longint history [NumTaps];
    longint expectQ [$];
    longint gotQ [$];
    int     accepted;
    int     seed;
    int     errorCount;
    int     resultCount;
    int     belowCount;
    int     aboveCount;
    int     testsPassed;
    int     testsFailed;

    convEngine #(
        .NumTaps  (NumTaps),
        .DataWidth(DataWidth)
    ) i_convEngine (
        .clk        (clk),
        .rst        (rst),
        .loadWeight (loadWeight),
        .weightIndex(weightIndex),
        .weightValue(weightValue),
        .sampleValid(sampleValid),
        .sample     (sample),
        .resultValid(resultValid),
        .result     (result),
        .pixel      (pixel)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // result monitor at the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        longint expSum;
        longint expMag;
        int     expPixel;
        if (rst === 1'b0 && resultValid === 1'b1) begin
            resultCount++;
            gotQ.push_back(longint'(result));
            if (expectQ.size() == 0) begin
                $display("unexpected result %0d at %0t ns, no sample is waiting", result, $time);
                errorCount++;
            end else begin
                expSum = expectQ.pop_front();
                expMag = (expSum < 0) ? -expSum : expSum;
                expPixel = (expMag > PixelMax) ? PixelMax : int'(expMag);
                if (expMag > PixelMax) begin
                    aboveCount++;
                end else begin
                    belowCount++;
                end
                if (longint'(result) != expSum) begin
                    $display("** Error at %0t ns: result %0d, expected %0d", $time, result, expSum);
                    errorCount++;
                end
                if (int'(pixel) != expPixel) begin
                    $display("** Error at %0t ns: pixel %0d, expected %0d", $time, pixel, expPixel);
                    errorCount++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus and model helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int randRange(input int lo, input int hi);
        int raw;
        raw = $random(seed);
        return lo + int'($unsigned(raw) % $unsigned(hi - lo + 1));
    endfunction

    // drive one cycle and predict what the next rising edge does
    task automatic step(input logic valid, input int value, input logic load,
                        input int index, input int wValue);
        longint acc;
        loadWeight  = load;
        weightIndex = IndexWidth'(index);
        weightValue = DataWidth'(wValue);
        sampleValid = valid;
        sample      = DataWidth'(value);
        if (valid) begin
            for (int k = NumTaps - 1; k > 0; k--) begin
                history[k] = history[k-1];
            end
            history[0] = longint'(value);
            accepted++;
            acc = 0;
            // old weights apply to a sample accepted at the same edge
            for (int k = 0; k < NumTaps; k++) begin
                acc += weights[k] * history[k];
            end
            if (accepted >= NumTaps) begin
                expectQ.push_back(acc);
            end
        end
        if (load) begin
            weights[index] = longint'(wValue);
        end
        @(negedge clk);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) step(1'b0, 0, 1'b0, 0, 0);
    endtask

    task automatic loadRandomWeights(input int lo, input int hi);
        for (int k = 0; k < NumTaps; k++) begin
            step(1'b0, 0, 1'b1, k, randRange(lo, hi));
        end
    endtask

    task automatic applyReset();
        rst = 1'b1;
        loadWeight = 1'b0;
        sampleValid = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < NumTaps; k++) begin
            weights[k] = 0;
            history[k] = 0;
        end
        accepted = 0;
        resultCount = 0;
        belowCount = 0;
        aboveCount = 0;
        expectQ.delete();
        gotQ.delete();
    endtask

    // wait for every queued result and then compare the result count
    task automatic drainAndCount();
        int waited;
        int want;
        waited = 0;
        while (expectQ.size() > 0 && waited < DrainLimit) begin
            idle(1);
            waited++;
        end
        if (expectQ.size() > 0) begin
            $display("timeout: %0d expected results never appeared", expectQ.size());
            errorCount++;
            expectQ.delete();
        end
        idle(Latency + 1);
        want = (accepted >= NumTaps) ? accepted - NumTaps + 1 : 0;
        if (resultCount != want) begin
            $display("** Error at %0t ns: %0d results, expected %0d", $time, resultCount, want);
            errorCount++;
        end
    endtask

    task automatic report(input string name, input int startErrors);
        if (errorCount == startErrors) begin
            testsPassed++;
            $display("test %s: ok, %0d results checked", name, resultCount);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", name, errorCount - startErrors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic resetAndFill();
        int startErrors;
        startErrors = errorCount;
        applyReset();
        loadRandomWeights(-1000, 1000);
        for (int n = 0; n < NumTaps - 1; n++) begin
            step(1'b1, randRange(-1000, 1000), 1'b0, 0, 0);
        end
        idle(Latency + 2);
        if (resultCount != 0) begin
            $display("a result came out before the chain held %0d samples", NumTaps);
            errorCount++;
        end
        step(1'b1, randRange(-1000, 1000), 1'b0, 0, 0);
        drainAndCount();
        report("reset and fill", startErrors);
    endtask

    task automatic impulseResponse();
        int startErrors;
        startErrors = errorCount;
        applyReset();
        for (int k = 0; k < NumTaps; k++) begin
            step(1'b0, 0, 1'b1, k, (k + 1) * ((k % 2) ? -113 : 97));
        end
        idle(1);
        for (int n = 0; n < NumTaps - 1; n++) begin
            step(1'b1, 0, 1'b0, 0, 0);
        end
        step(1'b1, 1, 1'b0, 0, 0);
        for (int n = 0; n < NumTaps - 1; n++) begin
            step(1'b1, 0, 1'b0, 0, 0);
        end
        drainAndCount();
        for (int k = 0; k < NumTaps && k < gotQ.size(); k++) begin
            if (gotQ[k] != weights[k]) begin
                $display("** Error at %0t ns: impulse tap %0d gave %0d, weight is %0d",
                         $time, k, gotQ[k], weights[k]);
                errorCount++;
            end
        end
        report("impulse response", startErrors);
    endtask

    // random stream with a given sample density and weight rewrite rate
    task automatic randomStream(input string name, input int validPct, input int loadPct);
        int   startErrors;
        logic valid;
        logic load;
        startErrors = errorCount;
        applyReset();
        loadRandomWeights(-32768, 32767);
        for (int n = 0; n < 200; n++) begin
            valid = randRange(0, 99) < validPct;
            load = randRange(0, 99) < loadPct;
            // force a rewrite on the same edge as an accepted sample now and then
            if (loadPct > 0 && (n % 8) == 0) begin
                valid = 1'b1;
                load = 1'b1;
            end
            step(valid, randRange(-32768, 32767), load, randRange(0, NumTaps - 1),
                 randRange(-32768, 32767));
        end
        drainAndCount();
        report(name, startErrors);
    endtask

    task automatic pixelSaturation();
        int startErrors;
        int pick;
        int value;
        startErrors = errorCount;
        applyReset();
        // extreme even taps and small odd taps put sums on both sides of 255
        for (int k = 0; k < NumTaps; k++) begin
            if (k % 2 == 0) begin
                step(1'b0, 0, 1'b1, k, randRange(0, 1) ? 32767 : -32768);
            end else begin
                step(1'b0, 0, 1'b1, k, randRange(-60, 60));
            end
        end
        for (int n = 0; n < 400; n++) begin
            pick = randRange(0, 7);
            value = (pick < 5) ? 0 : (pick < 7) ? randRange(-2, 2) : randRange(-32768, 32767);
            step(1'b1, value, 1'b0, 0, 0);
        end
        drainAndCount();
        if (belowCount == 0 || aboveCount == 0) begin
            $display("pixel range not covered: %0d results at or below %0d, %0d above",
                     belowCount, PixelMax, aboveCount);
            errorCount++;
        end
        report("pixel saturation", startErrors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed = 70851;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        clk = 1'b0;
        rst = 1'b1;
        loadWeight = 1'b0;
        weightIndex = '0;
        weightValue = '0;
        sampleValid = 1'b0;
        sample = '0;
        resetAndFill();
        impulseResponse();
        randomStream("back-to-back stream", 100, 0);
        randomStream("bursty input", 50, 0);
        randomStream("weight reload", 75, 30);
        pixelSaturation();
        $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("timeout: the run did not finish within %0d ns", WatchdogNs);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: convEngine.f
rtl/convPkg.sv
rtl/tapCell.sv
rtl/tapChain.sv
rtl/adderTree.sv
rtl/convControl.sv
rtl/resultStage.sv
rtl/convEngine.sv
sim/convEngine_chk.sv
sim/convEngineTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = convEngineTb
FILELIST = convEngine.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = Simulation passed

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILDDIR)/V$(TOP)

$(BUILDDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG) || { echo "run did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)
